// File: include/dac_sine_table.svh
// Quarter-wave sine table for the DDS tone lookup.
// Entry i holds round(32767 * sin((i + 0.5) * pi / 128)), so the table
// mirrors exactly about each quadrant edge.
// Included inside the tone module body and indexed by the six phase bits
// below the quadrant.

`ifndef DAC_SINE_TABLE_SVH
`define DAC_SINE_TABLE_SVH

localparam logic [15:0] dac_sine_qtr [64] = '{
  // **************************************************
  // 0 to pi/8
  16'd402,   16'd1206,
  16'd2009,  16'd2811,
  16'd3612,  16'd4410,
  16'd5205,  16'd5998,
  16'd6786,  16'd7571,
  16'd8351,  16'd9126,
  16'd9896,  16'd10659,
  16'd11417, 16'd12167,
  // **************************************************
  // pi/8 to pi/4
  16'd12910, 16'd13645,
  16'd14372, 16'd15090,
  16'd15800, 16'd16499,
  16'd17189, 16'd17869,
  16'd18537, 16'd19195,
  16'd19841, 16'd20475,
  16'd21096, 16'd21705,
  16'd22301, 16'd22884,
  // **************************************************
  // pi/4 to 3pi/8
  16'd23452, 16'd24007,
  16'd24547, 16'd25072,
  16'd25582, 16'd26077,
  16'd26556, 16'd27019,
  16'd27466, 16'd27896,
  16'd28310, 16'd28706,
  16'd29085, 16'd29447,
  16'd29791, 16'd30117,
  // **************************************************
  // 3pi/8 to pi/2, flattening near the peak
  16'd30424, 16'd30714,
  16'd30985, 16'd31237,
  16'd31470, 16'd31685,
  16'd31880, 16'd32057,
  16'd32213, 16'd32351,
  16'd32469, 16'd32567,
  16'd32646, 16'd32705,
  16'd32745, 16'd32765
};

`endif

// File: src/dac_chan_pkg.sv
// Shared constants and encodings for the DAC transmit channel.
// Import this package inside a module body; module headers refer to
// its widths by scoped name.

package dac_chan_pkg;

  // **************************************************
  // datapath geometry

  // one DAC sample
  localparam int sample_w = 16;
  // samples carried per dac_clk
  localparam int lanes = 4;
  // clocks from a phase register to the tone output
  localparam int dds_latency = 3;

  // **************************************************
  // encodings

  // sample source, values 8 to 15 fall back to the DDS
  typedef enum logic [3:0] {
    sel_dds      = 4'd0,
    sel_pat      = 4'd1,
    sel_dma      = 4'd2,
    sel_zero     = 4'd3,
    sel_pn7_inv  = 4'd4,
    sel_pn15_inv = 4'd5,
    sel_pn7      = 4'd6,
    sel_pn15     = 4'd7
  } dac_data_sel_e;

  // channel register map
  typedef enum logic [3:0] {
    reg_id      = 4'h0,
    reg_ctrl    = 4'h1,
    reg_tone1   = 4'h2,
    reg_tone2   = 4'h3,
    reg_scale   = 4'h4,
    reg_pattern = 4'h5
  } dac_reg_addr_e;

endpackage

// File: src/dac_pn_gen.sv
// PN7 and PN15 test sequence generators for the DAC channel.
// Each generator emits the next 64 sequence bits every dac_clk; a sync
// pulse restarts both from all ones. Lane 0 sits in bits 15:0 and holds
// the earliest bits, MSB first, followed by lanes 1 to 3.

`timescale 1ns/100ps

module dac_pn_gen (
  input  logic        dac_clk,
  input  logic        rst_n,
  input  logic        sync,
  output logic [63:0] pn7_data,
  output logic [63:0] pn15_data
);

  import dac_chan_pkg::*;

  localparam int word_w = 64;
  localparam int lane_w = word_w / lanes;

  // x^7 + x^6 + 1 and x^15 + x^14 + 1
  localparam int pn7_order = 7;
  localparam int pn15_order = 15;

  // **************************************************
  // sequence helpers

  // word bit that carries sequence bit t of this clock
  function automatic int bit_pos(input int t);
    return lane_w * (t / lane_w) + (lane_w - 1) - (t % lane_w);
  endfunction

  // next word of x^n + x^(n-1) + 1
  // the current word is the history the new bits are built from
  function automatic logic [word_w-1:0] pn_next(
    input logic [word_w-1:0] word,
    input int                order
  );
    logic [2*word_w-1:0] seq;
    logic [word_w-1:0]   next;
    seq = '0;
    next = '0;
    // unpack the current word into time order
    for (int t = 0; t < word_w; t++) begin
      seq[t] = word[bit_pos(t)];
    end
    // one serial LFSR step per new bit
    for (int t = word_w; t < 2 * word_w; t++) begin
      seq[t] = seq[t-order] ^ seq[t-order+1];
    end
    // pack the new bits back into lane order
    for (int t = 0; t < word_w; t++) begin
      next[bit_pos(t)] = seq[word_w+t];
    end
    return next;
  endfunction

  // **************************************************
  // sequence registers

  // all ones is a valid seed for both polynomials, so the
  // generators already run after reset
  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      pn7_data <= '1;
      pn15_data <= '1;
    end else if (sync) begin
      pn7_data <= '1;
      pn15_data <= '1;
    end else begin
      pn7_data <= pn_next(pn7_data, pn7_order);
      pn15_data <= pn_next(pn15_data, pn15_order);
    end
  end

endmodule

// File: src/dac_dds_tone.sv
// Two-tone DDS sample stage for one lane of the DAC channel.
// Takes two 16-bit phases and returns one sample three clocks later:
// quarter-wave sine lookup, scaling by an unsigned fraction, then a
// saturating sum. dds_format high gives two's complement, low gives
// offset binary.

`timescale 1ns/100ps

module dac_dds_tone (
  input  logic                              dac_clk,
  input  logic                              rst_n,
  input  logic                              dds_format,
  input  logic [dac_chan_pkg::sample_w-1:0] phase_1,
  input  logic [dac_chan_pkg::sample_w-1:0] phase_2,
  input  logic [dac_chan_pkg::sample_w-1:0] scale_1,
  input  logic [dac_chan_pkg::sample_w-1:0] scale_2,
  output logic [dac_chan_pkg::sample_w-1:0] sample
);

  import dac_chan_pkg::*;

  `include "dac_sine_table.svh"

  logic signed [sample_w-1:0] sine_1_q;
  logic signed [sample_w-1:0] sine_2_q;
  logic signed [2*sample_w:0] prod_1;
  logic signed [2*sample_w:0] prod_2;
  logic signed [sample_w-1:0] tone_1_q;
  logic signed [sample_w-1:0] tone_2_q;
  logic signed [sample_w:0]   sum;
  logic        [sample_w-1:0] sum_sat;

  // quadrant in bits 7:6, table index in bits 5:0
  // odd quadrants read the table backwards, the lower half negates
  function automatic logic signed [sample_w-1:0] quarter_lookup(input logic [7:0] ph);
    logic [5:0]          idx;
    logic [sample_w-1:0] mag;
    idx = ph[6] ? ~ph[5:0] : ph[5:0];
    mag = dac_sine_qtr[idx];
    return ph[7] ? -$signed(mag) : $signed(mag);
  endfunction

  // scale is a fraction of full scale, so keep the upper half
  assign prod_1 = sine_1_q * $signed({1'b0, scale_1});
  assign prod_2 = sine_2_q * $signed({1'b0, scale_2});

  // clamp to the signed range when the two tones overflow
  assign sum = tone_1_q + tone_2_q;
  assign sum_sat = (sum[sample_w] != sum[sample_w-1]) ?
                   {sum[sample_w], {(sample_w - 1){~sum[sample_w]}}} :
                   sum[sample_w-1:0];

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      sine_1_q <= '0;
      sine_2_q <= '0;
      tone_1_q <= '0;
      tone_2_q <= '0;
      sample <= '0;
    end else begin
      // stage 1, lookup
      sine_1_q <= quarter_lookup(phase_1[sample_w-1 -: 8]);
      sine_2_q <= quarter_lookup(phase_2[sample_w-1 -: 8]);
      // stage 2, scale
      tone_1_q <= prod_1[2*sample_w-1:sample_w];
      tone_2_q <= prod_2[2*sample_w-1:sample_w];
      // stage 3, sum and format
      sample <= {sum_sat[sample_w-1] ^ ~dds_format, sum_sat[sample_w-2:0]};
    end
  end

endmodule

// File: src/dac_dds.sv
// Four-lane DDS for the DAC channel.
// Holds two phase accumulators per lane, staggered by one increment so the
// lanes form consecutive samples, and feeds them to one tone stage per lane.
// A sync pulse reloads the phases and holds the output at zero until the
// tone pipeline carries the new phases.

`timescale 1ns/100ps

module dac_dds #(
  parameter bit datapath_disable = 1'b0
) (
  input  logic                                                 dac_clk,
  input  logic                                                 rst_n,
  input  logic                                                 sync,
  input  logic                                                 dds_format,
  input  logic [dac_chan_pkg::sample_w-1:0]                    scale_1,
  input  logic [dac_chan_pkg::sample_w-1:0]                    scale_2,
  input  logic [dac_chan_pkg::sample_w-1:0]                    init_1,
  input  logic [dac_chan_pkg::sample_w-1:0]                    init_2,
  input  logic [dac_chan_pkg::sample_w-1:0]                    incr_1,
  input  logic [dac_chan_pkg::sample_w-1:0]                    incr_2,
  output logic [dac_chan_pkg::lanes*dac_chan_pkg::sample_w-1:0] dds_data
);

  import dac_chan_pkg::*;

  localparam int cnt_w = $clog2(dds_latency + 1);

  logic [sample_w-1:0]       phase_1 [lanes];
  logic [sample_w-1:0]       phase_2 [lanes];
  logic [sample_w-1:0]       step_1;
  logic [sample_w-1:0]       step_2;
  logic [cnt_w-1:0]          fill_cnt;
  logic [lanes*sample_w-1:0] tone_word;

  // **************************************************
  // phase accumulators

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < lanes; k++) begin
        phase_1[k] <= '0;
        phase_2[k] <= '0;
      end
      step_1 <= '0;
      step_2 <= '0;
      fill_cnt <= '0;
    end else if (sync) begin
      // lane k starts k increments ahead, all lanes then step by lanes*incr
      for (int k = 0; k < lanes; k++) begin
        phase_1[k] <= init_1 + sample_w'(k) * incr_1;
        phase_2[k] <= init_2 + sample_w'(k) * incr_2;
      end
      step_1 <= sample_w'(lanes) * incr_1;
      step_2 <= sample_w'(lanes) * incr_2;
      fill_cnt <= cnt_w'(dds_latency);
    end else begin
      for (int k = 0; k < lanes; k++) begin
        phase_1[k] <= phase_1[k] + step_1;
        phase_2[k] <= phase_2[k] + step_2;
      end
      if (fill_cnt != '0) begin
        fill_cnt <= fill_cnt - 1'b1;
      end
    end
  end

  // **************************************************
  // tone stages

  if (datapath_disable) begin : g_no_tone
    assign tone_word = '0;
  end else begin : g_tone
    for (genvar k = 0; k < lanes; k++) begin : g_lane
      dac_dds_tone tone_i (
        .dac_clk    (dac_clk),
        .rst_n      (rst_n),
        .dds_format (dds_format),
        .phase_1    (phase_1[k]),
        .phase_2    (phase_2[k]),
        .scale_1    (scale_1),
        .scale_2    (scale_2),
        .sample     (tone_word[k*sample_w +: sample_w])
      );
    end
  end

  // old phases still in the pipeline are blanked
  assign dds_data = (fill_cnt == '0) ? tone_word : '0;

endmodule

// File: src/dac_chan_regs.sv
// Register file of the DAC channel, on the dac_clk domain.
// A one-clock reg_wreq writes and is acknowledged on the next edge; a
// one-clock reg_rreq returns the data with reg_rack one clock later.
// reg_rdata stays zero outside a read acknowledge.

`timescale 1ns/100ps

module dac_chan_regs #(
  parameter logic [31:0] chan_id = 32'h0
) (
  input  logic                                dac_clk,
  input  logic                                rst_n,
  input  logic                                reg_wreq,
  input  logic [3:0]                          reg_waddr,
  input  logic [31:0]                         reg_wdata,
  output logic                                reg_wack,
  input  logic                                reg_rreq,
  input  logic [3:0]                          reg_raddr,
  output logic [31:0]                         reg_rdata,
  output logic                                reg_rack,
  output dac_chan_pkg::dac_data_sel_e         data_sel,
  output logic                                dds_format,
  output logic [dac_chan_pkg::sample_w-1:0]   scale_1,
  output logic [dac_chan_pkg::sample_w-1:0]   scale_2,
  output logic [dac_chan_pkg::sample_w-1:0]   init_1,
  output logic [dac_chan_pkg::sample_w-1:0]   init_2,
  output logic [dac_chan_pkg::sample_w-1:0]   incr_1,
  output logic [dac_chan_pkg::sample_w-1:0]   incr_2,
  output logic [dac_chan_pkg::sample_w-1:0]   pat_1,
  output logic [dac_chan_pkg::sample_w-1:0]   pat_2
);

  import dac_chan_pkg::*;

  logic [31:0] rd_value;

  // write decode
  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_wack <= 1'b0;
      data_sel <= sel_dds;
      dds_format <= 1'b0;
      {init_1, incr_1} <= '0;
      {init_2, incr_2} <= '0;
      {scale_2, scale_1} <= '0;
      {pat_2, pat_1} <= '0;
    end else begin
      reg_wack <= reg_wreq;
      if (reg_wreq) begin
        case (dac_reg_addr_e'(reg_waddr))
          reg_ctrl: begin
            data_sel <= dac_data_sel_e'(reg_wdata[3:0]);
            dds_format <= reg_wdata[4];
          end
          reg_tone1: {init_1, incr_1} <= reg_wdata[2*sample_w-1:0];
          reg_tone2: {init_2, incr_2} <= reg_wdata[2*sample_w-1:0];
          reg_scale: {scale_2, scale_1} <= reg_wdata[2*sample_w-1:0];
          reg_pattern: {pat_2, pat_1} <= reg_wdata[2*sample_w-1:0];
          default: begin
          end
        endcase
      end
    end
  end

  // read mux, unmapped addresses read zero
  always_comb begin
    rd_value = '0;
    case (dac_reg_addr_e'(reg_raddr))
      reg_id: rd_value = chan_id;
      reg_ctrl: rd_value = {27'd0, dds_format, data_sel};
      reg_tone1: rd_value = {init_1, incr_1};
      reg_tone2: rd_value = {init_2, incr_2};
      reg_scale: rd_value = {scale_2, scale_1};
      reg_pattern: rd_value = {pat_2, pat_1};
      default: rd_value = '0;
    endcase
  end

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_rack <= 1'b0;
      reg_rdata <= '0;
    end else begin
      reg_rack <= reg_rreq;
      reg_rdata <= reg_rreq ? rd_value : '0;
    end
  end

endmodule

// File: src/dac_channel.sv
// Top level of one DAC transmit channel.
// Selects the 64-bit output word from the DDS, the PN generators, a fixed
// pattern, zero or DMA data under control of the channel registers.
// dac_data and dac_enable are registered one clock after the select.

`timescale 1ns/100ps

module dac_channel #(
  parameter logic [31:0] chan_id = 32'h0,
  parameter bit          datapath_disable = 1'b0
) (
  input  logic                                                 dac_clk,
  input  logic                                                 rst_n,
  input  logic                                                 dac_data_sync,
  input  logic [dac_chan_pkg::lanes*dac_chan_pkg::sample_w-1:0] dma_data,
  output logic [dac_chan_pkg::lanes*dac_chan_pkg::sample_w-1:0] dac_data,
  output logic                                                 dac_enable,
  input  logic                                                 reg_wreq,
  input  logic [3:0]                                           reg_waddr,
  input  logic [31:0]                                          reg_wdata,
  output logic                                                 reg_wack,
  input  logic                                                 reg_rreq,
  input  logic [3:0]                                           reg_raddr,
  output logic [31:0]                                          reg_rdata,
  output logic                                                 reg_rack
);

  import dac_chan_pkg::*;

  dac_data_sel_e             data_sel;
  logic                      dds_format;
  logic [sample_w-1:0]       scale_1;
  logic [sample_w-1:0]       scale_2;
  logic [sample_w-1:0]       init_1;
  logic [sample_w-1:0]       init_2;
  logic [sample_w-1:0]       incr_1;
  logic [sample_w-1:0]       incr_2;
  logic [sample_w-1:0]       pat_1;
  logic [sample_w-1:0]       pat_2;
  logic [lanes*sample_w-1:0] pn7_data;
  logic [lanes*sample_w-1:0] pn15_data;
  logic [lanes*sample_w-1:0] dds_data;

  // **************************************************
  // source select

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      dac_enable <= 1'b0;
      dac_data <= '0;
    end else begin
      // only DMA data is a real transmit stream
      dac_enable <= (data_sel == sel_dma);
      case (data_sel)
        sel_pn15: dac_data <= pn15_data;
        sel_pn7: dac_data <= pn7_data;
        sel_pn15_inv: dac_data <= ~pn15_data;
        sel_pn7_inv: dac_data <= ~pn7_data;
        sel_zero: dac_data <= '0;
        sel_dma: dac_data <= dma_data;
        sel_pat: dac_data <= {(lanes / 2){pat_2, pat_1}};
        default: dac_data <= dds_data;
      endcase
    end
  end

  // **************************************************
  // submodules

  dac_chan_regs #(.chan_id(chan_id)) regs_i (
    .dac_clk (dac_clk), .rst_n (rst_n),
    .reg_wreq (reg_wreq), .reg_waddr (reg_waddr), .reg_wdata (reg_wdata),
    .reg_wack (reg_wack), .reg_rreq (reg_rreq), .reg_raddr (reg_raddr),
    .reg_rdata (reg_rdata), .reg_rack (reg_rack),
    .data_sel (data_sel), .dds_format (dds_format),
    .scale_1 (scale_1), .scale_2 (scale_2), .init_1 (init_1), .init_2 (init_2),
    .incr_1 (incr_1), .incr_2 (incr_2), .pat_1 (pat_1), .pat_2 (pat_2)
  );

  dac_pn_gen pn_gen_i (
    .dac_clk   (dac_clk),
    .rst_n     (rst_n),
    .sync      (dac_data_sync),
    .pn7_data  (pn7_data),
    .pn15_data (pn15_data)
  );

  dac_dds #(.datapath_disable(datapath_disable)) dds_i (
    .dac_clk (dac_clk), .rst_n (rst_n), .sync (dac_data_sync),
    .dds_format (dds_format), .scale_1 (scale_1), .scale_2 (scale_2),
    .init_1 (init_1), .init_2 (init_2), .incr_1 (incr_1), .incr_2 (incr_2),
    .dds_data (dds_data)
  );

endmodule

// File: testbench/tb_dac_channel.sv
// Testbench for the DAC transmit channel top level.
// Drives the register bus, sync and DMA data on the falling edge and checks
// the registered outputs with concurrent assertions against bit-serial PN and
// $sin based DDS reference models. Runs reset, register, DMA, zero, pattern,
// PN, DDS and DDS format tests, then prints one summary line.

`timescale 1ns/100ps

module tb_dac_channel;

  import dac_chan_pkg::*;

  localparam logic [31:0] chan_id = 32'h0dac0001;
  localparam int period = 40;
  localparam int pn_words = 8;
  localparam int dds_words = 12;
  localparam int tol = 65536 / 32;
  localparam real pi = 3.14159265358979;
  // clock budget per test group
  localparam int test_cycles = 8 + 40 + 50 + 4 * (pn_words + 8) + 3 * (dds_words + 20);
  localparam int timeout_cycles = test_cycles + 100;

  logic        dac_clk;
  logic        rst_n;
  logic        dac_data_sync;
  logic [63:0] dma_data;
  logic [63:0] dac_data;
  logic        dac_enable;
  logic        reg_wreq;
  logic [3:0]  reg_waddr;
  logic [31:0] reg_wdata;
  logic        reg_wack;
  logic        reg_rreq;
  logic [3:0]  reg_raddr;
  logic [31:0] reg_rdata;
  logic        reg_rack;

  integer      seed = 72;
  int          errors = 0;
  int          words = 0;
  logic [31:0] rd_exp;
  logic [31:0] rd_exp_q;
  logic        wack_exp;
  logic        rack_exp;
  logic [1:0]  chk_mode;
  logic        chk_en;
  logic        exp_en;
  logic [63:0] exp_data;
  int          exp_dds [lanes];
  logic        dds_ok;
  logic [14:0] hist;
  logic [63:0] captured [dds_words];

  dac_channel #(.chan_id(chan_id), .datapath_disable(1'b0)) dut_i (
    .dac_clk (dac_clk), .rst_n (rst_n), .dac_data_sync (dac_data_sync),
    .dma_data (dma_data), .dac_data (dac_data), .dac_enable (dac_enable),
    .reg_wreq (reg_wreq), .reg_waddr (reg_waddr), .reg_wdata (reg_wdata),
    .reg_wack (reg_wack), .reg_rreq (reg_rreq), .reg_raddr (reg_raddr),
    .reg_rdata (reg_rdata), .reg_rack (reg_rack)
  );

  initial begin
    dac_clk = 1'b0;
    forever #(period / 2) dac_clk = ~dac_clk;
  end

  // **************************************************
  // bus protocol expectations and checks

  always @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      wack_exp <= 1'b0;
      rack_exp <= 1'b0;
      rd_exp_q <= '0;
    end else begin
      wack_exp <= reg_wreq;
      rack_exp <= reg_rreq;
      rd_exp_q <= reg_rreq ? rd_exp : 32'd0;
    end
  end

  // every lane within tolerance of the DDS model
  always_comb begin
    int got;
    dds_ok = 1'b1;
    for (int k = 0; k < lanes; k++) begin
      got = int'($signed(dac_data[k*sample_w +: sample_w]));
      if (got - exp_dds[k] > tol || exp_dds[k] - got > tol) begin
        dds_ok = 1'b0;
      end
    end
  end

  a_wack: assert property (@(posedge dac_clk) disable iff (!rst_n) reg_wack == wack_exp)
    else begin
      errors++;
      $display("** Error at %0t: reg_wack %b, expected %b", $time, $sampled(reg_wack),
               $sampled(wack_exp));
    end
  a_rack: assert property (@(posedge dac_clk) disable iff (!rst_n) reg_rack == rack_exp)
    else begin
      errors++;
      $display("** Error at %0t: reg_rack %b, expected %b", $time, $sampled(reg_rack),
               $sampled(rack_exp));
    end
  a_rdata: assert property (@(posedge dac_clk) disable iff (!rst_n) reg_rdata == rd_exp_q)
    else begin
      errors++;
      $display("** Error at %0t: reg_rdata %h, expected %h", $time, $sampled(reg_rdata),
               $sampled(rd_exp_q));
    end
  a_data: assert property (@(posedge dac_clk) disable iff (!rst_n)
                           chk_mode == 2'd1 |-> dac_data == exp_data)
    else begin
      errors++;
      $display("** Error at %0t: dac_data %h, expected %h", $time, $sampled(dac_data),
               $sampled(exp_data));
    end
  a_dds: assert property (@(posedge dac_clk) disable iff (!rst_n) chk_mode == 2'd2 |-> dds_ok)
    else begin
      errors++;
      $display("** Error at %0t: DDS word %h, expected lanes %0d %0d %0d %0d", $time,
               $sampled(dac_data), exp_dds[0], exp_dds[1], exp_dds[2], exp_dds[3]);
    end
  a_enable: assert property (@(posedge dac_clk) disable iff (!rst_n)
                             chk_en |-> dac_enable == exp_en)
    else begin
      errors++;
      $display("** Error at %0t: dac_enable %b, expected %b", $time, $sampled(dac_enable),
               $sampled(exp_en));
    end

  // **************************************************
  // stimulus tasks and reference models

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
    @(negedge dac_clk);
    reg_wreq = 1'b1;
    reg_waddr = addr;
    reg_wdata = data;
    @(negedge dac_clk);
    reg_wreq = 1'b0;
  endtask

  task automatic reg_read(input logic [3:0] addr, input logic [31:0] expected);
    @(negedge dac_clk);
    reg_rreq = 1'b1;
    reg_raddr = addr;
    rd_exp = expected;
    @(negedge dac_clk);
    reg_rreq = 1'b0;
  endtask

  // select a source, return once the output follows it
  task automatic set_source(input dac_data_sel_e sel, input logic fmt);
    chk_mode = 2'd0;
    chk_en = 1'b0;
    reg_write(reg_ctrl, {27'd0, fmt, sel});
    @(negedge dac_clk);
    chk_en = 1'b1;
    exp_en = (sel == sel_dma);
  endtask

  task automatic pulse_sync();
    @(negedge dac_clk);
    dac_data_sync = 1'b1;
    @(negedge dac_clk);
    dac_data_sync = 1'b0;
  endtask

  // serial LFSR, hist[0] is the newest bit; lane k in bits 16k+15:16k, MSB first
  task automatic pn_advance(input int order, output logic [63:0] word);
    logic nb;
    word = '0;
    for (int t = 0; t < 64; t++) begin
      nb = hist[order-1] ^ hist[order-2];
      hist = {hist[13:0], nb};
      word[16*(t/16) + 15 - (t%16)] = nb;
    end
  endtask

  task automatic check_pn(input dac_data_sel_e sel, input int order, input logic inv);
    logic [63:0] word;
    set_source(sel, 1'b0);
    pulse_sync();
    @(negedge dac_clk);
    hist = '1;
    exp_data = {64{~inv}};
    chk_mode = 2'd1;
    words++;
    for (int j = 0; j < pn_words; j++) begin
      @(negedge dac_clk);
      pn_advance(order, word);
      exp_data = word ^ {64{inv}};
      words++;
    end
    @(negedge dac_clk);
    chk_mode = 2'd0;
  endtask

  function automatic int tone_model(input int p1, input int p2, input int s1, input int s2);
    real v;
    v = 32767.0 * (s1 * $sin(2.0 * pi * p1 / 65536.0) + s2 * $sin(2.0 * pi * p2 / 65536.0));
    v = v / 65536.0;
    if (v > 32767.0) begin
      v = 32767.0;
    end
    if (v < -32768.0) begin
      v = -32768.0;
    end
    return $rtoi(v);
  endfunction

  // fmt 1 checks against the model and captures, fmt 0 expects the capture with MSBs flipped
  task automatic check_dds(input int init_1, input int incr_1, input int init_2,
                           input int incr_2, input int s1, input int s2, input logic fmt);
    int p1;
    int p2;
    reg_write(reg_tone1, {init_1[15:0], incr_1[15:0]});
    reg_write(reg_tone2, {init_2[15:0], incr_2[15:0]});
    reg_write(reg_scale, {s2[15:0], s1[15:0]});
    set_source(sel_dds, fmt);
    pulse_sync();
    @(negedge dac_clk);
    // pipeline still filling
    exp_data = '0;
    chk_mode = 2'd1;
    repeat (2) @(negedge dac_clk);
    for (int j = 0; j < dds_words; j++) begin
      @(negedge dac_clk);
      if (fmt) begin
        for (int k = 0; k < lanes; k++) begin
          p1 = (init_1 + k * incr_1 + j * lanes * incr_1) & 16'hffff;
          p2 = (init_2 + k * incr_2 + j * lanes * incr_2) & 16'hffff;
          exp_dds[k] = tone_model(p1, p2, s1, s2);
        end
        chk_mode = 2'd2;
        captured[j] = dac_data;
      end else begin
        exp_data = captured[j] ^ {lanes{16'h8000}};
      end
      words++;
    end
    @(negedge dac_clk);
    chk_mode = 2'd0;
  endtask

  // **************************************************
  // test sequence

  initial begin
    #(timeout_cycles * period);
    $display("watchdog: run did not finish within %0d clocks", timeout_cycles);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    dac_data_sync = 1'b0;
    dma_data = '0;
    reg_wreq = 1'b0;
    reg_waddr = '0;
    reg_wdata = '0;
    reg_rreq = 1'b0;
    reg_raddr = '0;
    rd_exp = '0;
    chk_mode = 2'd0;
    chk_en = 1'b0;
    exp_en = 1'b0;
    exp_data = '0;
    hist = '1;
    for (int k = 0; k < lanes; k++) begin
      exp_dds[k] = 0;
    end
    repeat (3) @(negedge dac_clk);
    rst_n = 1'b1;

    // reset state, the free-running DDS takes over after the first clock
    chk_en = 1'b1;
    chk_mode = 2'd1;
    @(negedge dac_clk);
    chk_mode = 2'd0;
    reg_read(reg_ctrl, 32'd0);
    repeat (2) @(negedge dac_clk);

    // register readback
    reg_write(reg_tone1, 32'h12345678);
    reg_write(reg_tone2, 32'h9abcdef0);
    reg_write(reg_scale, 32'h0f1e2d3c);
    reg_write(reg_pattern, 32'h5e19a7c3);
    reg_write(reg_ctrl, 32'hffffffe3);
    reg_read(reg_tone1, 32'h12345678);
    reg_read(reg_tone2, 32'h9abcdef0);
    reg_read(reg_scale, 32'h0f1e2d3c);
    reg_read(reg_pattern, 32'h5e19a7c3);
    reg_read(reg_ctrl, 32'h00000003);
    reg_read(reg_id, chan_id);
    reg_read(4'hf, 32'd0);

    // DMA pass-through, one clock behind
    set_source(sel_dma, 1'b0);
    chk_mode = 2'd1;
    for (int i = 0; i < 16; i++) begin
      exp_data = dma_data;
      dma_data = {$random(seed), $random(seed)};
      words++;
      @(negedge dac_clk);
    end

    set_source(sel_zero, 1'b0);
    exp_data = '0;
    chk_mode = 2'd1;
    repeat (4) @(negedge dac_clk);
    words += 4;

    set_source(sel_pat, 1'b0);
    exp_data = {2{32'h5e19a7c3}};
    chk_mode = 2'd1;
    repeat (4) @(negedge dac_clk);
    words += 4;

    check_pn(sel_pn7, 7, 1'b0);
    check_pn(sel_pn15, 15, 1'b0);
    check_pn(sel_pn7_inv, 7, 1'b1);
    check_pn(sel_pn15_inv, 15, 1'b1);

    check_dds(16'h1000, 16'h0400, 16'h0000, 16'h0a00, 16'h6000, 16'h4000, 1'b1);
    check_dds(16'h1000, 16'h0400, 16'h0000, 16'h0a00, 16'h6000, 16'h4000, 1'b0);
    // large scales drive the sum into saturation
    check_dds(16'h3000, 16'h0123, 16'h2000, 16'h0777, 16'hc000, 16'hc000, 1'b1);

    repeat (2) @(negedge dac_clk);
    $display("tb_dac_channel: %0d errors over %0d checked words", errors, words);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
src/dac_chan_pkg.sv
src/dac_pn_gen.sv
src/dac_dds_tone.sv
src/dac_dds.sv
src/dac_chan_regs.sv
src/dac_channel.sv
testbench/tb_dac_channel.sv

// File: Makefile
TOP = tb_dac_channel

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Finished with no errors"

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
